// ==== conv_defs.svh ====
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define LWIDTH  4   // Size and coordinate values.
`define IMG_MAX 8   // Largest image side.
`define FMAX    3   // Largest filter side.
`define IADDR   6   // Image buffer address, log2 of IMG_MAX squared.
`define WADDR   4   // Weight tap index, covers FMAX squared taps.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DWIDTH  8   // Signed pixel.
`define WWIDTH  8   // Signed weight.
`define PWIDTH  20  // Signed windowed sum of products.
`define RWIDTH  24  // Signed accumulated feature.
`define FACCUM  6   // Feature memory address, up to 64 features.

// Latencies, counted from the command to the block output.
`define D_CONV  2
`define D_ACCUM 1

`endif

// ==== conv_pkg.sv ====
`include "conv_defs.svh"

package conv_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control word
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic start;  // Begins a layer result.
    logic valid;  // One data word in this cycle.
    logic stop;   // Last data word of a sweep.
  } ctrl_t;

  // Window origin handed to the execute stage.
  typedef struct packed {
    ctrl_t              ctrl;
    logic [`LWIDTH-1:0] x;
    logic [`LWIDTH-1:0] y;
  } conv_cmd_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // States
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Phase supplied by the core sequencer.
  typedef enum logic [1:0] {
    CORE_WAIT,
    CORE_NETWORK,
    CORE_INPUT,
    CORE_OUTPUT
  } core_state_t;

  // Layer FSM inside the decode block.
  typedef enum logic {
    S_WAIT,
    S_ACTIVE
  } ctrl_state_t;

endpackage

// ==== ctrl_conv.sv ====
`timescale 1ns/1ps
`include "conv_defs.svh"

module ctrl_conv (
  input  logic                  clk,
  input  logic                  xrst,
  input  conv_pkg::ctrl_t       in_ctrl,
  input  conv_pkg::core_state_t core_state,
  input  logic [`LWIDTH-1:0]    img_size,
  input  logic [`LWIDTH-1:0]    fil_size,
  input  logic                  first_input,
  input  logic                  last_input,
  output logic                  img_we,
  output logic [`IADDR-1:0]     img_addr,
  output conv_pkg::conv_cmd_t   conv_cmd,
  output logic [`LWIDTH-1:0]    fil_size_q,
  output conv_pkg::ctrl_t       accum_ctrl,
  output logic                  feat_we,
  output logic                  feat_rst,
  output logic [`FACCUM-1:0]    feat_addr,
  output logic [`FACCUM-1:0]    feat_addr_d,
  output logic                  conv_oe,
  output conv_pkg::ctrl_t       out_ctrl,
  output logic [`LWIDTH-1:0]    fea_size
);

  localparam int DOUT = `D_CONV + `D_ACCUM;

  conv_pkg::ctrl_state_t         state;
  conv_pkg::core_state_t         core_q;
  logic                          wait_back;
  logic [`LWIDTH-1:0]            img_size_q;
  logic [`LWIDTH-1:0]            x;
  logic [`LWIDTH-1:0]            y;
  logic                          pixel_in;
  logic                          issue;
  logic                          img_xend;
  logic                          img_last;
  logic                          fea_xend;
  logic                          fea_last;
  logic [`D_CONV-1:0]            rst_pipe;
  logic [`D_CONV:0][`FACCUM-1:0] addr_pipe;
  conv_pkg::ctrl_t [DOUT-1:0]    ctrl_pipe;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Layer FSM and sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= conv_pkg::S_WAIT;
    end else begin
      case (state)
        conv_pkg::S_WAIT:   if (in_ctrl.start) state <= conv_pkg::S_ACTIVE;
        conv_pkg::S_ACTIVE: if (out_ctrl.stop) state <= conv_pkg::S_WAIT;
        default:            state <= conv_pkg::S_WAIT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      core_q <= conv_pkg::CORE_WAIT;
    end else begin
      core_q <= core_state;  // Phase changes act one cycle late.
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      img_size_q <= '0;
      fil_size_q <= '0;
      fea_size   <= '0;
    end else if (state == conv_pkg::S_WAIT && in_ctrl.start) begin
      img_size_q <= img_size;
      fil_size_q <= fil_size;
      fea_size   <= img_size - fil_size + `LWIDTH'(1);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Position counters
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign pixel_in = state == conv_pkg::S_ACTIVE && core_q == conv_pkg::CORE_INPUT
                    && in_ctrl.valid;
  assign issue    = state == conv_pkg::S_ACTIVE && core_q == conv_pkg::CORE_OUTPUT
                    && !wait_back;
  assign img_xend = x == img_size_q - `LWIDTH'(1);
  assign img_last = img_xend && y == img_size_q - `LWIDTH'(1);
  assign fea_xend = x == fea_size - `LWIDTH'(1);
  assign fea_last = fea_xend && y == fea_size - `LWIDTH'(1);

  assign img_we   = pixel_in;
  assign img_addr = `IADDR'(y * `IMG_MAX + x);  // Row-major image buffer.

  always_ff @(posedge clk) begin
    if (!xrst) begin
      x <= '0;
      y <= '0;
    end else if (state == conv_pkg::S_WAIT) begin
      x <= '0;
      y <= '0;
    end else if (pixel_in) begin
      x <= img_xend ? '0 : x + `LWIDTH'(1);
      if (img_xend) y <= img_last ? '0 : y + `LWIDTH'(1);
    end else if (issue) begin
      x <= fea_xend ? '0 : x + `LWIDTH'(1);
      if (fea_xend) y <= fea_last ? '0 : y + `LWIDTH'(1);
    end
  end

  // Held after the last window until the next layer start.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      wait_back <= 1'b0;
    end else if (in_ctrl.start) begin
      wait_back <= 1'b0;
    end else if (issue && fea_last) begin
      wait_back <= 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command and delay lines
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!xrst) begin
      conv_cmd <= '0;
    end else begin
      conv_cmd.ctrl.start <= pixel_in && last_input && img_last;
      conv_cmd.ctrl.valid <= issue;
      conv_cmd.ctrl.stop  <= issue && fea_last;
      conv_cmd.x          <= x;
      conv_cmd.y          <= y;
    end
  end

  // Stage 0 is the running feature index of the current command.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      addr_pipe <= '0;
      rst_pipe  <= '0;
      ctrl_pipe <= '0;
    end else begin
      if (conv_cmd.ctrl.valid) begin
        addr_pipe[0] <= conv_cmd.ctrl.stop ? '0 : addr_pipe[0] + `FACCUM'(1);
      end
      for (int i = 1; i <= `D_CONV; i++) addr_pipe[i] <= addr_pipe[i-1];
      rst_pipe[0] <= conv_cmd.ctrl.valid && first_input;
      for (int i = 1; i < `D_CONV; i++) rst_pipe[i] <= rst_pipe[i-1];
      ctrl_pipe[0] <= conv_cmd.ctrl;
      for (int i = 1; i < DOUT; i++) ctrl_pipe[i] <= ctrl_pipe[i-1];
    end
  end

  assign accum_ctrl  = ctrl_pipe[`D_CONV-1];  // Aligned with the execute sum.
  assign feat_we     = accum_ctrl.valid;
  assign feat_rst    = rst_pipe[`D_CONV-1];
  assign feat_addr   = addr_pipe[`D_CONV-1];  // Read one cycle ahead of the write.
  assign feat_addr_d = addr_pipe[`D_CONV];
  assign out_ctrl    = ctrl_pipe[DOUT-1];
  assign conv_oe     = ctrl_pipe[DOUT-2].valid;

  a_valid_active: assert property (@(posedge clk) disable iff (!xrst)
    conv_cmd.ctrl.valid |-> state == conv_pkg::S_ACTIVE);

  // The stop word closes the sweep, so no word follows it.
  a_stop_valid: assert property (@(posedge clk) disable iff (!xrst)
    out_ctrl.stop |-> out_ctrl.valid ##1 !out_ctrl.valid);

endmodule

// ==== conv_mac.sv ====
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_mac (
  input  logic                       clk,
  input  logic                       xrst,
  input  logic                       img_we,
  input  logic [`IADDR-1:0]          img_addr,
  input  logic signed [`DWIDTH-1:0]  pixel,
  input  logic                       w_we,
  input  logic [`WADDR-1:0]          w_addr,
  input  logic signed [`WWIDTH-1:0]  w_data,
  input  conv_pkg::conv_cmd_t        cmd,
  input  logic [`LWIDTH-1:0]         fil_size,
  output logic signed [`PWIDTH-1:0]  sum
);

  localparam int NTAP   = `FMAX * `FMAX;
  localparam int MWIDTH = `DWIDTH + `WWIDTH;

  logic signed [`DWIDTH-1:0] img_mem [`IMG_MAX*`IMG_MAX];
  logic signed [`WWIDTH-1:0] weight  [NTAP];
  logic signed [MWIDTH-1:0]  prod_d  [NTAP];
  logic signed [MWIDTH-1:0]  prod_q  [NTAP];
  logic signed [`PWIDTH-1:0] tree;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Buffers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (img_we) img_mem[img_addr] <= pixel;
  end

  always_ff @(posedge clk) begin
    if (w_we) weight[w_addr] <= w_data;  // Tap index is row times FMAX plus column.
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage 1, window products
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar r = 0; r < `FMAX; r++) begin : g_row
    for (genvar c = 0; c < `FMAX; c++) begin : g_col
      logic [`IADDR-1:0]        addr;
      logic                     tap_on;
      logic signed [MWIDTH-1:0] mult;

      assign addr   = `IADDR'((int'(cmd.y) + r) * `IMG_MAX + int'(cmd.x) + c);
      assign tap_on = r < fil_size && c < fil_size;
      assign mult   = img_mem[addr] * weight[r*`FMAX+c];
      assign prod_d[r*`FMAX+c] = tap_on ? mult : '0;  // Taps outside the filter add nothing.
    end
  end

  always_ff @(posedge clk) begin
    prod_q <= prod_d;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage 2, adder tree
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    tree = '0;
    for (int i = 0; i < NTAP; i++) tree = tree + prod_q[i];
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      sum <= '0;
    end else begin
      sum <= tree;
    end
  end

  a_window_inside: assert property (@(posedge clk) disable iff (!xrst)
    cmd.ctrl.valid |-> int'(cmd.x) + int'(fil_size) <= `IMG_MAX
                    && int'(cmd.y) + int'(fil_size) <= `IMG_MAX);

endmodule

// ==== feat_accum.sv ====
`timescale 1ns/1ps
`include "conv_defs.svh"

module feat_accum (
  input  logic                       clk,
  input  logic                       xrst,
  input  logic                       feat_we,
  input  logic                       feat_rst,
  input  logic [`FACCUM-1:0]         feat_addr,
  input  logic [`FACCUM-1:0]         feat_addr_d,
  input  logic signed [`PWIDTH-1:0]  sum,
  output logic signed [`RWIDTH-1:0]  out_data
);

  logic signed [`RWIDTH-1:0] feat_mem [2**`FACCUM];
  logic signed [`RWIDTH-1:0] rd_q;
  logic signed [`RWIDTH-1:0] sum_ext;
  logic signed [`RWIDTH-1:0] wdata;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read-modify-write
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    rd_q <= feat_mem[feat_addr];  // Ready in the cycle the sum arrives.
  end

  assign sum_ext = `RWIDTH'(sum);
  assign wdata   = feat_rst ? sum_ext : rd_q + sum_ext;  // The first channel starts from zero.

  always_ff @(posedge clk) begin
    if (feat_we) feat_mem[feat_addr_d] <= wdata;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      out_data <= '0;
    end else if (feat_we) begin
      out_data <= wdata;
    end
  end

  a_rst_with_we: assert property (@(posedge clk) disable iff (!xrst)
    feat_rst |-> feat_we);

endmodule

// ==== conv_layer.sv ====
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_layer (
  input  logic                       clk,
  input  logic                       xrst,
  input  conv_pkg::ctrl_t            in_ctrl,
  input  conv_pkg::core_state_t      core_state,
  input  logic [`LWIDTH-1:0]         img_size,
  input  logic [`LWIDTH-1:0]         fil_size,
  input  logic                       first_input,
  input  logic                       last_input,
  input  logic signed [`DWIDTH-1:0]  pixel,
  input  logic                       w_we,
  input  logic [`WADDR-1:0]          w_addr,
  input  logic signed [`WWIDTH-1:0]  w_data,
  output conv_pkg::ctrl_t            out_ctrl,
  output logic signed [`RWIDTH-1:0]  out_data,
  output logic                       conv_oe,
  output logic [`LWIDTH-1:0]         fea_size
);

  logic                      img_we;
  logic [`IADDR-1:0]         img_addr;
  conv_pkg::conv_cmd_t       conv_cmd;
  logic [`LWIDTH-1:0]        fil_size_q;
  conv_pkg::ctrl_t           accum_ctrl;
  logic                      feat_we;
  logic                      feat_rst;
  logic [`FACCUM-1:0]        feat_addr;
  logic [`FACCUM-1:0]        feat_addr_d;
  logic signed [`PWIDTH-1:0] conv_sum;

  ctrl_conv u_ctrl (
    .clk(clk), .xrst(xrst), .in_ctrl(in_ctrl), .core_state(core_state),
    .img_size(img_size), .fil_size(fil_size),
    .first_input(first_input), .last_input(last_input),
    .img_we(img_we), .img_addr(img_addr), .conv_cmd(conv_cmd), .fil_size_q(fil_size_q),
    .accum_ctrl(accum_ctrl), .feat_we(feat_we), .feat_rst(feat_rst),
    .feat_addr(feat_addr), .feat_addr_d(feat_addr_d),
    .conv_oe(conv_oe), .out_ctrl(out_ctrl), .fea_size(fea_size)
  );

  conv_mac u_mac (
    .clk(clk), .xrst(xrst), .img_we(img_we), .img_addr(img_addr), .pixel(pixel),
    .w_we(w_we), .w_addr(w_addr), .w_data(w_data),
    .cmd(conv_cmd), .fil_size(fil_size_q), .sum(conv_sum)
  );

  feat_accum u_accum (
    .clk(clk), .xrst(xrst), .feat_we(feat_we), .feat_rst(feat_rst),
    .feat_addr(feat_addr), .feat_addr_d(feat_addr_d),
    .sum(conv_sum), .out_data(out_data)
  );

  // The last write of a sweep lands on the last feature of the map.
  a_sweep_end: assert property (@(posedge clk) disable iff (!xrst)
    accum_ctrl.stop |-> int'(feat_addr_d) == int'(fea_size) * int'(fea_size) - 1);

endmodule

// ==== tb_conv_layer.sv ====
`timescale 1ns/1ps
`include "conv_defs.svh"

module tb_conv_layer;

  localparam int NLAYERS  = 6;
  localparam int CH_MAX   = 3;
  localparam int NTAP     = `FMAX * `FMAX;
  localparam int CH_WORST = NTAP + 6 + 2 * `IMG_MAX * `IMG_MAX + 12;  // One channel at most.
  localparam int LIMIT    = 2 * (16 + NLAYERS * CH_MAX * CH_WORST);

  logic                      clk = 1'b0;
  logic                      xrst;
  conv_pkg::ctrl_t           in_ctrl;
  conv_pkg::core_state_t     core_state;
  logic [`LWIDTH-1:0]        img_size;
  logic [`LWIDTH-1:0]        fil_size;
  logic                      first_input;
  logic                      last_input;
  logic signed [`DWIDTH-1:0] pixel;
  logic                      w_we;
  logic [`WADDR-1:0]         w_addr;
  logic signed [`WWIDTH-1:0] w_data;
  conv_pkg::ctrl_t           out_ctrl;
  logic signed [`RWIDTH-1:0] out_data;
  logic                      conv_oe;
  logic [`LWIDTH-1:0]        fea_size;

  logic [31:0]               lfsr = 32'h3fb7_5af9;
  int                        cyc = 0;
  int                        checks = 0;
  int                        errors = 0;
  int                        words = 0;
  int                        starts = 0;
  int                        start_due = -1;
  logic                      last_px;
  logic                      stop_seen = 1'b0;
  logic                      prev_oe = 1'b0;
  logic                      seen_valid = 1'b0;
  int                        img_m [`IMG_MAX*`IMG_MAX];
  int                        wgt_m [NTAP];
  int                        feat_m [2**`FACCUM];  // Running feature sums.
  logic signed [`RWIDTH-1:0] exp_q [$];

  conv_layer uut (
    .clk(clk), .xrst(xrst), .in_ctrl(in_ctrl), .core_state(core_state),
    .img_size(img_size), .fil_size(fil_size),
    .first_input(first_input), .last_input(last_input), .pixel(pixel),
    .w_we(w_we), .w_addr(w_addr), .w_data(w_data),
    .out_ctrl(out_ctrl), .out_data(out_data), .conv_oe(conv_oe), .fea_size(fea_size)
  );

  always #50 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Random source and reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        b;
    val = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ 32'h8020_0003;  // Galois taps 32, 22, 2, 1.
      val  = {val[30:0], b};
    end
    return val;
  endfunction

  function automatic int window_sum(input int x, input int y, input int fil);
    int acc;
    acc = 0;
    for (int r = 0; r < fil; r++) begin
      for (int c = 0; c < fil; c++) begin
        acc += img_m[(y + r) * `IMG_MAX + x + c] * wgt_m[r * `FMAX + c];
      end
    end
    return acc;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_ctrl(input string name, input conv_pkg::ctrl_t got,
                            input conv_pkg::ctrl_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input logic signed [`RWIDTH-1:0] got,
                            input logic signed [`RWIDTH-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_size(input string name, input logic [`LWIDTH-1:0] got,
                            input logic [`LWIDTH-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output monitor
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk) begin : monitor
    conv_pkg::ctrl_t exp_c;
    if (xrst) begin
      // The pixel is taken at the next edge and the start follows three edges later.
      if (in_ctrl.valid && last_px && last_input) start_due = cyc + 4;
      exp_c       = '0;
      exp_c.start = cyc == start_due;
      if (out_ctrl.start) starts++;
      if (out_ctrl.valid) begin
        seen_valid = 1'b1;
        if (exp_q.size() == 0) begin
          errors++;
          $display("%0t: out_ctrl.valid came with no feature word pending", $time);
        end else begin
          exp_c.valid = 1'b1;
          exp_c.stop  = exp_q.size() == 1;  // Last word of the map.
          check_data("out_data", out_data, exp_q.pop_front());
          words++;
        end
      end else if (!seen_valid) begin
        check_data("out_data", out_data, '0);
      end
      check_ctrl("out_ctrl", out_ctrl, exp_c);
      check_bit("out_ctrl.valid", out_ctrl.valid, prev_oe);
      if (out_ctrl.stop) stop_seen = 1'b1;
      prev_oe = conv_oe;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Every slot gets a random weight, the ones outside the filter too.
  task automatic load_weights();
    logic [`WWIDTH-1:0] w;
    for (int t = 0; t < NTAP; t++) begin
      @(posedge clk);
      w        = rand_bits(`WWIDTH);
      wgt_m[t] = int'($signed(w));
      w_we    <= 1'b1;
      w_addr  <= `WADDR'(t);
      w_data  <= w;
    end
  endtask

  task automatic run_channel(input int img, input int fil, input bit first, input bit last);
    logic [`DWIDTH-1:0] p;
    int                 fea;
    int                 idx;
    fea = img - fil + 1;
    load_weights();
    @(posedge clk);
    w_we        <= 1'b0;
    img_size    <= `LWIDTH'(img);
    fil_size    <= `LWIDTH'(fil);
    first_input <= first;
    last_input  <= last;
    in_ctrl     <= '{start: 1'b1, valid: 1'b0, stop: 1'b0};
    @(posedge clk);
    in_ctrl <= '0;
    @(negedge clk);
    check_size("fea_size", fea_size, `LWIDTH'(fea));
    @(posedge clk);
    core_state <= conv_pkg::CORE_INPUT;  // Seen by the DUT one cycle late.
    for (int y = 0; y < img; y++) begin
      for (int x = 0; x < img; x++) begin
        @(posedge clk);
        p                       = rand_bits(`DWIDTH);
        img_m[y * `IMG_MAX + x] = int'($signed(p));
        pixel                  <= p;
        in_ctrl                <= '{start: 1'b0, valid: 1'b1, stop: 1'b0};
        last_px                <= y == img - 1 && x == img - 1;
      end
    end
    @(posedge clk);
    in_ctrl <= '0;
    last_px <= 1'b0;
    for (int y = 0; y < fea; y++) begin
      for (int x = 0; x < fea; x++) begin
        idx         = y * fea + x;
        feat_m[idx] = (first ? 0 : feat_m[idx]) + window_sum(x, y, fil);
        exp_q.push_back(`RWIDTH'(feat_m[idx]));
      end
    end
    words      = 0;
    stop_seen  = 1'b0;
    core_state <= conv_pkg::CORE_OUTPUT;
    while (!stop_seen) @(posedge clk);
    core_state <= conv_pkg::CORE_WAIT;
    if (words != fea * fea) begin
      errors++;
      $display("%0t: output phase gave %0d words instead of %0d", $time, words, fea * fea);
    end
    repeat (4) @(posedge clk);
  endtask

  initial begin
    int img;
    int fil;
    int nch;
    int err0;
    xrst        = 1'b0;
    in_ctrl     = '0;
    core_state  = conv_pkg::CORE_WAIT;
    img_size    = '0;
    fil_size    = '0;
    first_input = 1'b0;
    last_input  = 1'b0;
    pixel       = '0;
    w_we        = 1'b0;
    w_addr      = '0;
    w_data      = '0;
    last_px     = 1'b0;
    repeat (16) @(posedge clk);
    xrst <= 1'b1;
    for (int l = 0; l < NLAYERS; l++) begin
      img    = `FMAX + int'(rand_bits(3) % (`IMG_MAX - `FMAX + 1));
      fil    = 1 + int'(rand_bits(2) % `FMAX);
      nch    = 1 + int'(rand_bits(2) % CH_MAX);
      err0   = errors;
      starts = 0;
      for (int ch = 0; ch < nch; ch++) run_channel(img, fil, ch == 0, ch == nch - 1);
      if (starts != 1) begin
        errors++;
        $display("%0t: layer %0d gave %0d start pulses instead of one", $time, l, starts);
      end
      $display("layer %0d: image %0d filter %0d channels %0d errors %0d",
               l, img, fil, nch, errors - err0);
    end
    $display("layers %0d checks %0d errors %0d", NLAYERS, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    wait (cyc >= LIMIT);
    $display("%0t: run did not finish within %0d cycles", $time, LIMIT);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== conv_layer.f ====
+incdir+.
conv_pkg.sv
ctrl_conv.sv
conv_mac.sv
feat_accum.sv
conv_layer.sv
tb_conv_layer.sv

// ==== Bender.yml ====
package:
  name: conv_layer

export_include_dirs:
  - .

sources:
  - conv_pkg.sv
  - ctrl_conv.sv
  - conv_mac.sv
  - feat_accum.sv
  - conv_layer.sv
  - target: test
    files:
      - tb_conv_layer.sv
